//--- cpu_pkg.sv
package cpu_pkg;

  localparam int data_w  = 16;  // word width
  localparam int paddr_w = 10;  // physical ram address

  typedef logic [data_w-1:0]  word_t;
  typedef logic [paddr_w-1:0] paddr_t;

  localparam int page_size = 72;  // words per page
  localparam int num_pages = 14;  // 14 x 72 fits in 1024 words
  localparam int off_w     = $clog2(page_size);

  typedef logic [off_w-1:0] off_t;

  // logical pages below reset_pages start in the physical page of the same index
  localparam int reset_pages = 2;

  localparam int program_start = 46;  // logical address of first instruction

  localparam logic [7:0] op_jmp       = 8'd1;
  localparam logic [7:0] op_ram2reg   = 8'd2;  // ram -> reg
  localparam logic [7:0] op_reg2ram   = 8'd3;  // reg -> ram
  localparam logic [7:0] op_num2reg   = 8'd4;  // value -> reg
  localparam logic [7:0] op_reg_plus  = 8'd5;  // reg += value
  localparam logic [7:0] op_reg_minus = 8'd6;  // reg -= value

  // two-word instruction as seen by execute
  typedef struct packed {
    logic [7:0] op;       // high byte of first word
    logic [7:0] reg_num;  // low byte of first word
    word_t      operand;  // second word
  } instr_t;

endpackage

//--- mem_req_if.sv
interface mem_req_if;

  // client side
  logic           req;    // level, held until ack
  logic           write;
  cpu_pkg::word_t vaddr;  // logical address
  cpu_pkg::word_t wdata;

  // mmu side
  logic           ack;    // one-cycle pulse
  cpu_pkg::word_t rdata;  // valid in the ack cycle of a read

  modport client (
    output req,
    output write,
    output vaddr,
    output wdata,
    input  ack,
    input  rdata
  );

  modport server (
    input  req,
    input  write,
    input  vaddr,
    input  wdata,
    output ack,
    output rdata
  );

endinterface

//--- issue_if.sv
interface issue_if;

  // fetch to execute
  logic            instr_valid;  // one-cycle pulse
  cpu_pkg::instr_t instr;        // held until the next fetch

  // execute back to fetch
  logic            done;         // one-cycle pulse at completion
  logic            jump_en;      // valid with done
  cpu_pkg::word_t  jump_target;

  modport fetch (
    output instr_valid,
    output instr,
    input  done,
    input  jump_en,
    input  jump_target
  );

  modport exec (
    input  instr_valid,
    input  instr,
    output done,
    output jump_en,
    output jump_target
  );

endinterface

//--- fetch_stage.sv
module fetch_stage (
  input  logic      clka,
  input  logic      rst,
  mem_req_if.client mem,
  issue_if.fetch    iss
);

  typedef enum logic [1:0] {
    f_word1,  // opcode and register word
    f_word2,  // operand word
    f_wait    // instruction in execute
  } state_t;

  state_t         state;
  cpu_pkg::word_t pc;
  cpu_pkg::word_t first_word;

  // fetch only reads
  assign mem.write = 1'b0;
  assign mem.wdata = '0;
  assign mem.vaddr = (state == f_word2) ? pc + cpu_pkg::word_t'(1) : pc;

  always_ff @(posedge clka) begin
    if (!rst) begin
      state           <= f_word1;
      pc              <= cpu_pkg::word_t'(cpu_pkg::program_start);
      mem.req         <= 1'b0;
      iss.instr_valid <= 1'b0;
    end else begin
      iss.instr_valid <= 1'b0;
      case (state)
        f_word1, f_word2: begin
          if (mem.ack) begin
            mem.req <= 1'b0;  // drop in the cycle after ack
            if (state == f_word1) begin
              state <= f_word2;
            end else begin
              state           <= f_wait;
              iss.instr_valid <= 1'b1;
            end
          end else begin
            mem.req <= 1'b1;
          end
        end
        f_wait: begin
          if (iss.done) begin
            pc    <= iss.jump_en ? iss.jump_target : pc + cpu_pkg::word_t'(2);
            state <= f_word1;
          end
        end
        default: state <= f_word1;
      endcase
    end
  end

  // instruction words, captured on ack
  always_ff @(posedge clka) begin
    if (mem.ack) begin
      if (state == f_word1) begin
        first_word <= mem.rdata;
      end else begin
        iss.instr <= cpu_pkg::instr_t'({first_word, mem.rdata});
      end
    end
  end

endmodule

//--- exec_stage.sv
module exec_stage #(
  parameter int reg_count = 16
) (
  input  logic      clka,
  input  logic      rst,
  issue_if.exec     iss,
  mem_req_if.client mem
);

  localparam int idx_w = $clog2(reg_count);

  cpu_pkg::word_t   regs [reg_count];
  logic [idx_w-1:0] idx;
  logic [7:0]       op;
  cpu_pkg::word_t   operand;
  cpu_pkg::word_t   cur_val;
  logic             is_mem_op;
  logic             rf_we;
  cpu_pkg::word_t   rf_wdata;

  // instr stays stable until fetch sees done
  assign op        = iss.instr.op;
  assign operand   = iss.instr.operand;
  assign idx       = iss.instr.reg_num[idx_w-1:0];
  assign cur_val   = regs[idx];
  assign is_mem_op = (op == cpu_pkg::op_ram2reg) || (op == cpu_pkg::op_reg2ram);

  // register write port
  always_comb begin
    rf_we    = 1'b0;
    rf_wdata = operand;
    if (mem.req) begin
      rf_we    = mem.ack && !mem.write;  // ram2reg load
      rf_wdata = mem.rdata;
    end else if (iss.instr_valid) begin
      case (op)
        cpu_pkg::op_num2reg: begin
          rf_we = 1'b1;
        end
        cpu_pkg::op_reg_plus: begin
          rf_we    = 1'b1;
          rf_wdata = cur_val + operand;  // wraps at 16 bits
        end
        cpu_pkg::op_reg_minus: begin
          rf_we    = 1'b1;
          rf_wdata = cur_val - operand;
        end
        default: rf_we = 1'b0;
      endcase
    end
  end

  always_ff @(posedge clka) begin
    if (rf_we) begin
      regs[idx] <= rf_wdata;
    end
  end

  // completion and data request control
  always_ff @(posedge clka) begin
    if (!rst) begin
      mem.req     <= 1'b0;
      iss.done    <= 1'b0;
      iss.jump_en <= 1'b0;
    end else begin
      iss.done    <= 1'b0;
      iss.jump_en <= 1'b0;
      if (mem.req) begin
        if (mem.ack) begin
          mem.req  <= 1'b0;
          iss.done <= 1'b1;  // one cycle after ack
        end
      end else if (iss.instr_valid) begin
        if (is_mem_op) begin
          mem.req <= 1'b1;
        end else begin
          iss.done    <= 1'b1;
          iss.jump_en <= (op == cpu_pkg::op_jmp);
        end
      end
    end
  end

  // request fields and jump target
  always_ff @(posedge clka) begin
    if (iss.instr_valid && !mem.req) begin
      mem.write       <= (op == cpu_pkg::op_reg2ram);
      mem.vaddr       <= operand;
      mem.wdata       <= cur_val;
      iss.jump_target <= operand;
    end
  end

endmodule

//--- mmu.sv
module mmu #(
  parameter int num_pages = 14
) (
  input  logic            clka,
  input  logic            rst,
  input  cpu_pkg::word_t  rd_data,
  mem_req_if.server       fetch_port,
  mem_req_if.server       data_port,
  output logic            wr_en,
  output cpu_pkg::paddr_t wr_addr,
  output cpu_pkg::word_t  wr_data,
  output logic            rd_en,
  output cpu_pkg::paddr_t rd_addr,
  output logic            fault
);

  localparam int pg_w = $clog2(num_pages);

  typedef logic [pg_w-1:0] ppage_t;

  typedef enum logic [2:0] {
    m_idle,
    m_walk,   // follow the page chain
    m_alloc,  // scan for a free page
    m_issue,  // ram access on the port
    m_rdack   // read data back
  } state_t;

  state_t               state;
  ppage_t               next_page [num_pages];  // 0 marks chain end
  cpu_pkg::word_t       page_tag  [num_pages];  // logical page held
  logic [num_pages-1:0] used;

  ppage_t          walk_ptr;
  ppage_t          scan_ptr;
  ppage_t          ppage_q;
  ppage_t          last_ppage;
  cpu_pkg::word_t  last_lpage;
  cpu_pkg::word_t  lpage_q;
  cpu_pkg::word_t  wdata_q;
  cpu_pkg::off_t   off_q;
  logic            sel_q;  // 1 = data client
  logic            wr_q;

  logic            sel_data;
  logic            any_req;
  cpu_pkg::word_t  req_vaddr;
  cpu_pkg::word_t  req_lpage;
  logic            ack_now;
  cpu_pkg::paddr_t phys_addr;

  // fetch wins
  assign sel_data  = !fetch_port.req;
  assign any_req   = fetch_port.req || data_port.req;
  assign req_vaddr = sel_data ? data_port.vaddr : fetch_port.vaddr;
  assign req_lpage = req_vaddr / cpu_pkg::word_t'(cpu_pkg::page_size);

  assign phys_addr = cpu_pkg::paddr_t'(ppage_q * cpu_pkg::page_size + off_q);

  assign rd_en   = (state == m_issue) && !wr_q;
  assign wr_en   = (state == m_issue) && wr_q;
  assign rd_addr = phys_addr;
  assign wr_addr = phys_addr;
  assign wr_data = wdata_q;

  // writes ack at issue, reads when data returns
  assign ack_now          = ((state == m_issue) && wr_q) || (state == m_rdack);
  assign fetch_port.ack   = ack_now && !sel_q;
  assign data_port.ack    = ack_now && sel_q;
  assign fetch_port.rdata = rd_data;
  assign data_port.rdata  = rd_data;

  always_ff @(posedge clka) begin
    if (!rst) begin
      state      <= m_idle;
      fault      <= 1'b0;
      walk_ptr   <= '0;
      scan_ptr   <= '0;
      ppage_q    <= '0;
      last_lpage <= '0;  // logical 0 sits in physical 0
      last_ppage <= '0;
      for (int i = 0; i < num_pages; i++) begin
        used[i]      <= (i < cpu_pkg::reset_pages);
        page_tag[i]  <= (i < cpu_pkg::reset_pages) ? cpu_pkg::word_t'(i) : '0;
        next_page[i] <= (i + 1 < cpu_pkg::reset_pages) ? ppage_t'(i + 1) : '0;
      end
    end else begin
      case (state)
        m_idle: begin
          if (any_req && !fault) begin
            if (req_lpage == last_lpage) begin
              ppage_q <= last_ppage;  // reuse last translation
              state   <= m_issue;
            end else begin
              walk_ptr <= '0;  // chain head
              state    <= m_walk;
            end
          end
        end
        m_walk: begin
          if (page_tag[walk_ptr] == lpage_q) begin
            ppage_q    <= walk_ptr;
            last_lpage <= lpage_q;
            last_ppage <= walk_ptr;
            state      <= m_issue;
          end else if (next_page[walk_ptr] == '0) begin
            scan_ptr <= '0;  // walk_ptr stays on the tail
            state    <= m_alloc;
          end else begin
            walk_ptr <= next_page[walk_ptr];
          end
        end
        m_alloc: begin
          if (!used[scan_ptr]) begin
            used[scan_ptr]      <= 1'b1;
            page_tag[scan_ptr]  <= lpage_q;
            next_page[walk_ptr] <= scan_ptr;  // link at chain end
            ppage_q             <= scan_ptr;
            last_lpage          <= lpage_q;
            last_ppage          <= scan_ptr;
            state               <= m_issue;
          end else if (scan_ptr == ppage_t'(num_pages - 1)) begin
            fault <= 1'b1;  // out of pages, never serves again
            state <= m_idle;
          end else begin
            scan_ptr <= scan_ptr + 1'b1;
          end
        end
        m_issue: state <= wr_q ? m_idle : m_rdack;
        m_rdack: state <= m_idle;
        default: state <= m_idle;
      endcase
    end
  end

  // request capture
  always_ff @(posedge clka) begin
    if (state == m_idle && any_req) begin
      sel_q   <= sel_data;
      wr_q    <= sel_data ? data_port.write : fetch_port.write;
      wdata_q <= sel_data ? data_port.wdata : fetch_port.wdata;
      lpage_q <= req_lpage;
      off_q   <= cpu_pkg::off_t'(req_vaddr % cpu_pkg::word_t'(cpu_pkg::page_size));
    end
  end

endmodule

//--- cpu_core.sv
module cpu_core #(
  parameter int reg_count = 16,
  parameter int num_pages = cpu_pkg::num_pages
) (
  input  logic            clka,
  input  logic            rst,
  input  cpu_pkg::word_t  ram_rd_data,
  output logic            ram_wr_en,
  output cpu_pkg::paddr_t ram_wr_addr,
  output cpu_pkg::word_t  ram_wr_data,
  output logic            ram_rd_en,
  output cpu_pkg::paddr_t ram_rd_addr,
  output logic            mmu_fault
);

  mem_req_if fetch_req ();  // program reads
  mem_req_if data_req ();   // ram2reg and reg2ram
  issue_if   iss ();

  fetch_stage u_fetch (
    .clka (clka),
    .rst  (rst),
    .mem  (fetch_req),
    .iss  (iss)
  );

  exec_stage #(
    .reg_count (reg_count)
  ) u_exec (
    .clka (clka),
    .rst  (rst),
    .iss  (iss),
    .mem  (data_req)
  );

  mmu #(
    .num_pages (num_pages)
  ) u_mmu (
    .clka       (clka),
    .rst        (rst),
    .rd_data    (ram_rd_data),
    .fetch_port (fetch_req),
    .data_port  (data_req),
    .wr_en      (ram_wr_en),
    .wr_addr    (ram_wr_addr),
    .wr_data    (ram_wr_data),
    .rd_en      (ram_rd_en),
    .rd_addr    (ram_rd_addr),
    .fault      (mmu_fault)
  );

endmodule

//--- tb_ram_model.sv
module tb_ram_model (
  input  logic            clka,
  input  logic            load,     // copy image in, clear the log
  input  cpu_pkg::word_t  image [1024],
  input  logic            rd_en,
  input  cpu_pkg::paddr_t rd_addr,
  output cpu_pkg::word_t  rd_data,
  input  logic            wr_en,
  input  cpu_pkg::paddr_t wr_addr,
  input  cpu_pkg::word_t  wr_data,
  output int              log_count,
  output cpu_pkg::paddr_t log_addr [16],
  output cpu_pkg::word_t  log_data [16]
);
  timeunit 1ns;
  timeprecision 1ps;

  cpu_pkg::word_t mem [1024];

  always @(posedge clka) begin
    if (load) begin
      mem       <= image;
      rd_data   <= '0;
      log_count <= 0;
    end else begin
      if (rd_en) begin
        rd_data <= mem[rd_addr];  // data one cycle after rd_en
      end
      if (wr_en) begin
        mem[wr_addr]             <= wr_data;
        log_addr[log_count[3:0]] <= wr_addr;  // log wraps after 16 writes
        log_data[log_count[3:0]] <= wr_data;
        log_count                <= log_count + 1;
      end
    end
  end

endmodule

//--- tb_cpu.sv
module tb_cpu;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int reset_cycles = 4;
  localparam int max_cycles   = 4000;  // twice the summed test lengths
  localparam int wait_limit   = 1500;
  localparam int settle       = 60;    // quiet cycles after the last store

  logic            clka = 1'b0;
  logic            rst;
  logic            load;
  cpu_pkg::word_t  ram_rd_data;
  logic            ram_wr_en;
  cpu_pkg::paddr_t ram_wr_addr;
  cpu_pkg::word_t  ram_wr_data;
  logic            ram_rd_en;
  cpu_pkg::paddr_t ram_rd_addr;
  logic            mmu_fault;

  cpu_pkg::word_t  image [1024];
  int              log_count;
  cpu_pkg::paddr_t log_addr [16];
  cpu_pkg::word_t  log_data [16];

  int              seed;
  int              errors;
  int              passed;
  int              cycle_count = 0;
  int              prog_ptr;
  int              ref_tag [$];  // logical page per physical page
  cpu_pkg::paddr_t exp_addr [$];
  cpu_pkg::word_t  exp_data [$];
  bit              want_fault;
  bit              rd_ok [1024];  // physical words the program may read
  bit              reads_live = 1'b0;

  cpu_core dut (
    .clka        (clka),
    .rst         (rst),
    .ram_rd_data (ram_rd_data),
    .ram_wr_en   (ram_wr_en),
    .ram_wr_addr (ram_wr_addr),
    .ram_wr_data (ram_wr_data),
    .ram_rd_en   (ram_rd_en),
    .ram_rd_addr (ram_rd_addr),
    .mmu_fault   (mmu_fault)
  );

  tb_ram_model ram (
    .clka      (clka),
    .load      (load),
    .image     (image),
    .rd_en     (ram_rd_en),
    .rd_addr   (ram_rd_addr),
    .rd_data   (ram_rd_data),
    .wr_en     (ram_wr_en),
    .wr_addr   (ram_wr_addr),
    .wr_data   (ram_wr_data),
    .log_count (log_count),
    .log_addr  (log_addr),
    .log_data  (log_data)
  );

  always #20 clka = ~clka;

  always @(posedge clka) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= max_cycles) begin
      $display("run stopped after %0d cycles without finishing", cycle_count);
      $display("Something failed");
      $finish;
    end
  end

  // reads must land on a program word or on preloaded data
  always @(negedge clka) begin
    if (reads_live && ram_rd_en) begin
      assert (rd_ok[ram_rd_addr]) else begin
        $display("FAILED ram_rd_addr: got 0x%h, not a program or data word", ram_rd_addr);
        errors++;
      end
    end
  end

  // reset chain plus lowest free page in first-touch order
  function automatic int ref_phys(int vaddr);
    int lpage;
    lpage = vaddr / cpu_pkg::page_size;
    for (int p = 0; p < ref_tag.size(); p++) begin
      if (ref_tag[p] == lpage) begin
        return p * cpu_pkg::page_size + vaddr % cpu_pkg::page_size;
      end
    end
    if (ref_tag.size() == cpu_pkg::num_pages) begin
      return -1;  // no free page left
    end
    ref_tag.push_back(lpage);
    return (ref_tag.size() - 1) * cpu_pkg::page_size + vaddr % cpu_pkg::page_size;
  endfunction

  function automatic void new_program();
    image = '{default: '0};
    rd_ok = '{default: 1'b0};
    ref_tag = '{0, 1};
    exp_addr.delete();
    exp_data.delete();
    want_fault = 1'b0;
    prog_ptr = cpu_pkg::program_start;
  endfunction

  function automatic void emit(logic [7:0] op, logic [7:0] rn, cpu_pkg::word_t operand);
    int pa_op;
    int pa_val;
    pa_op  = ref_phys(prog_ptr);
    pa_val = ref_phys(prog_ptr + 1);
    image[cpu_pkg::paddr_t'(pa_op)]  = {op, rn};
    image[cpu_pkg::paddr_t'(pa_val)] = operand;
    rd_ok[cpu_pkg::paddr_t'(pa_op)]  = 1'b1;
    rd_ok[cpu_pkg::paddr_t'(pa_val)] = 1'b1;
    prog_ptr += 2;
  endfunction

  function automatic void store_and_expect(logic [7:0] rn, int vaddr, cpu_pkg::word_t data);
    int pa;
    emit(cpu_pkg::op_reg2ram, rn, cpu_pkg::word_t'(vaddr));
    pa = ref_phys(vaddr);
    if (pa < 0) begin
      want_fault = 1'b1;  // this store never reaches the ram
    end else begin
      exp_addr.push_back(cpu_pkg::paddr_t'(pa));
      exp_data.push_back(data);
    end
  endfunction

  function automatic void emit_halt();
    emit(cpu_pkg::op_jmp, 8'd0, cpu_pkg::word_t'(prog_ptr));  // jump to itself
  endfunction

  task automatic apply_reset();
    @(posedge clka);
    rst  <= 1'b0;
    load <= 1'b1;
    @(posedge clka);
    load <= 1'b0;
    repeat (reset_cycles - 1) @(posedge clka);
    rst <= 1'b1;
  endtask

  task automatic run_check(input string name);
    int errs_before;
    int waited;
    int slips;
    errs_before = errors;
    apply_reset();
    reads_live = 1'b1;
    waited = 0;
    while ((log_count < exp_addr.size() || (want_fault && !mmu_fault)) &&
           waited < wait_limit) begin
      @(negedge clka);
      waited++;
    end
    slips = 0;
    repeat (settle) begin
      @(negedge clka);
      if (mmu_fault != want_fault) slips++;
    end
    reads_live = 1'b0;
    assert (waited < wait_limit) else begin
      $display("%s: stores or fault did not show up within %0d cycles", name, wait_limit);
      errors++;
    end
    assert (slips == 0) else begin
      $display("FAILED mmu_fault: 0x%h in %0d cycles, expected 0x%h", !want_fault, slips,
               want_fault);
      errors++;
    end
    assert (log_count == exp_addr.size()) else begin
      $display("FAILED ram_wr_en pulses: got 0x%h expected 0x%h", log_count, exp_addr.size());
      errors++;
    end
    for (int i = 0; i < exp_addr.size() && i < log_count && i < 16; i++) begin
      assert (log_addr[i[3:0]] == exp_addr[i]) else begin
        $display("FAILED ram_wr_addr #%0d: got 0x%h expected 0x%h", i, log_addr[i[3:0]],
                 exp_addr[i]);
        errors++;
      end
      assert (log_data[i[3:0]] == exp_data[i]) else begin
        $display("FAILED ram_wr_data #%0d: got 0x%h expected 0x%h", i, log_data[i[3:0]],
                 exp_data[i]);
        errors++;
      end
    end
    if (errors == errs_before) passed++;
    $display("%s: %s", name, (errors == errs_before) ? "pass" : "FAIL");
  endtask

  task automatic immediate_store();
    cpu_pkg::word_t v;
    v = cpu_pkg::word_t'($random(seed));
    new_program();
    emit(cpu_pkg::op_num2reg, 8'd1, v);
    store_and_expect(8'd1, 60, v);
    emit_halt();
    run_check("num2reg then reg2ram");
  endtask

  task automatic add_sub_store();
    cpu_pkg::word_t v;
    cpu_pkg::word_t a;
    cpu_pkg::word_t b;
    v = cpu_pkg::word_t'($random(seed));
    a = cpu_pkg::word_t'($random(seed));
    b = cpu_pkg::word_t'($random(seed));
    new_program();
    emit(cpu_pkg::op_num2reg, 8'd2, v);
    emit(cpu_pkg::op_reg_plus, 8'd2, a);
    emit(cpu_pkg::op_reg_minus, 8'd2, b);
    store_and_expect(8'd2, 61, v + a - b);  // 16-bit wrap
    emit_halt();
    run_check("plus and minus");
  endtask

  task automatic load_then_store();
    cpu_pkg::word_t v;
    v = cpu_pkg::word_t'($random(seed));
    new_program();
    image[cpu_pkg::paddr_t'(ref_phys(65))] = v;
    rd_ok[cpu_pkg::paddr_t'(ref_phys(65))] = 1'b1;
    emit(cpu_pkg::op_ram2reg, 8'd3, 16'd65);
    store_and_expect(8'd3, 100, v);
    emit_halt();
    run_check("ram2reg then reg2ram");
  endtask

  task automatic jump_over_store();
    cpu_pkg::word_t v;
    v = cpu_pkg::word_t'($random(seed));
    new_program();
    emit(cpu_pkg::op_num2reg, 8'd4, v);
    emit(cpu_pkg::op_jmp, 8'd0, cpu_pkg::word_t'(prog_ptr + 4));
    emit(cpu_pkg::op_reg2ram, 8'd4, 16'd80);  // skipped
    store_and_expect(8'd4, 81, v);
    emit_halt();
    run_check("jump over a store");
  endtask

  task automatic page_reuse_stores();
    cpu_pkg::word_t v;
    int addrs [$] = '{5 * 72 + 7, 3 * 72 + 40, 5 * 72 + 30};
    new_program();
    for (int k = 0; k < addrs.size(); k++) begin
      v = cpu_pkg::word_t'($random(seed));
      emit(cpu_pkg::op_num2reg, 8'd5, v);
      store_and_expect(8'd5, addrs[k], v);
    end
    emit_halt();
    run_check("pages 5, 3, 5");
  endtask

  task automatic page_exhaustion();
    cpu_pkg::word_t v;
    v = cpu_pkg::word_t'($random(seed));
    new_program();
    emit(cpu_pkg::op_num2reg, 8'd6, v);
    for (int k = 0; k < 13; k++) begin
      emit(cpu_pkg::op_reg_plus, 8'd6, 16'd1);
      v = v + 16'd1;
      store_and_expect(8'd6, (k + 2) * cpu_pkg::page_size + k * 5, v);
    end
    emit_halt();
    run_check("out of pages");
  endtask

  initial begin
    rst    <= 1'b0;
    load   <= 1'b1;  // clears the ram model and its read port
    image  = '{default: '0};
    seed   = 19796;
    errors = 0;
    passed = 0;
    immediate_store();
    add_sub_store();
    load_then_store();
    jump_over_store();
    page_reuse_stores();
    page_exhaustion();
    $display("tests passed: %0d of 6, failed checks: %0d", passed, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

//--- project.f
cpu_pkg.sv
mem_req_if.sv
issue_if.sv
fetch_stage.sv
exec_stage.sv
mmu.sv
cpu_core.sv
tb_ram_model.sv
tb_cpu.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_cpu -f project.f -o tb_cpu_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_cpu_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation returned status $status"
  exit 1
fi

if grep -q "Everything OK" "$log"; then
  echo "PASS"
  exit 0
fi
echo "FAIL"
exit 1
